/* fpu_pkg.sv */
package fpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // single precision format
  //////////////////////////////////////////////////////////////////////
  localparam int EXP_W    = 8;    // biased exponent
  localparam int FRAC_W   = 23;   // stored fraction, no hidden bit
  localparam int WORD_W   = 32;
  localparam int EXP_BIAS = 127;
  localparam int SUM_W    = 28;   // carry, hidden, fraction, guard, round, sticky

  // the only nan the unit ever writes back
  localparam logic [WORD_W-1:0] CANONICAL_NAN = 32'h7FC00000;

  //////////////////////////////////////////////////////////////////////
  // opcodes and rounding modes
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    OP_ADD    = 3'd0,
    OP_SUB    = 3'd1,
    OP_CMP_EQ = 3'd2,
    OP_CMP_LT = 3'd3,
    OP_CMP_LE = 3'd4,
    OP_CMP_UN = 3'd5
  } fpu_op_e;

  typedef enum logic [1:0] {
    RM_NEAREST   = 2'd0,  // ties to even
    RM_ZERO      = 2'd1,
    RM_PLUS_INF  = 2'd2,
    RM_MINUS_INF = 2'd3
  } rmode_e;

  // one operand after unpacking
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W:0]   sig;      // hidden bit on top, zero for zero/denormal
    logic              is_zero;
    logic              is_inf;
    logic              is_snan;
    logic              is_qnan;
  } opnd_class_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
    logic zero;
  } fpcsr_t;

endpackage

/* fpu_stage_if.sv */
`timescale 1ns/1ps

// adder to rounder payload, the valid bit lives in the issue control
interface fpu_stage_if;

  logic                       sign;        // sign of larger operand
  logic [fpu_pkg::EXP_W-1:0]  exp;         // larger exponent, pre-normalize
  logic [fpu_pkg::SUM_W-1:0]  sig;         // raw sum with g/r/s
  logic                       eff_sub;     // true subtraction took place
  logic                       is_nan;
  logic                       is_inf;
  logic                       invalid;
  fpu_pkg::fpu_op_e           op;
  fpu_pkg::rmode_e            rmode;
  logic                       cmp_flag;    // comparator result rides along
  logic                       cmp_invalid;

  modport adder (
    output sign, exp, sig, eff_sub, is_nan, is_inf, invalid,
    output op, rmode, cmp_flag, cmp_invalid
  );

  modport rounder (
    input sign, exp, sig, eff_sub, is_nan, is_inf, invalid,
    input op, rmode, cmp_flag, cmp_invalid
  );

endinterface

/* fpu_operand_class.sv */
`timescale 1ns/1ps

module fpu_operand_class (
  input  logic [fpu_pkg::WORD_W-1:0] word_i,
  output fpu_pkg::opnd_class_t       class_o
);

  logic [fpu_pkg::EXP_W-1:0]  exp;
  logic [fpu_pkg::FRAC_W-1:0] frac;
  logic                       exp_zero;
  logic                       exp_ones;

  assign exp      = word_i[fpu_pkg::WORD_W-2 -: fpu_pkg::EXP_W];
  assign frac     = word_i[fpu_pkg::FRAC_W-1:0];
  assign exp_zero = ~|exp;   // zero or denormal
  assign exp_ones = &exp;    // inf or nan

  always_comb begin
    class_o.sign    = word_i[fpu_pkg::WORD_W-1];
    class_o.exp     = exp;
    // denormals flushed, hidden bit only for normal numbers
    class_o.sig     = exp_zero ? '0 : {1'b1, frac};
    class_o.is_zero = exp_zero;
    class_o.is_inf  = exp_ones & ~|frac;
    // quiet bit is the fraction msb
    class_o.is_snan = exp_ones & ~frac[fpu_pkg::FRAC_W-1] & |frac[fpu_pkg::FRAC_W-2:0];
    class_o.is_qnan = exp_ones & frac[fpu_pkg::FRAC_W-1];
  end

endmodule

/* fpu_issue_ctrl.sv */
`timescale 1ns/1ps

module fpu_issue_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic flush_i,
  input  logic issue_i,
  input  logic take_i,
  output logic ready_o,
  output logic out_full_o,
  output logic adv_o,
  output logic s1_valid_o,
  output logic s2_valid_o
);

  logic s1_valid_q;   // issue register (align)
  logic s2_valid_q;   // add register
  logic out_valid_q;  // output register in the rounder

  // whole pipe moves when the output slot is free or being taken
  assign adv_o   = ~out_valid_q | take_i;
  assign ready_o = adv_o;

  //////////////////////////////////////////////////////////////////////
  // per-stage valid bits
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      // kills in-flight ops and anything issued this cycle
      s1_valid_q  <= 1'b0;
      s2_valid_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (adv_o) begin
      s1_valid_q  <= issue_i;      // accepted, since ready == adv
      s2_valid_q  <= s1_valid_q;
      out_valid_q <= s2_valid_q;
    end
  end

  assign s1_valid_o = s1_valid_q;
  assign s2_valid_o = s2_valid_q;
  assign out_full_o = out_valid_q;

endmodule

/* fpu_fcmp.sv */
`timescale 1ns/1ps

module fpu_fcmp (
  input  fpu_pkg::opnd_class_t a_i,
  input  fpu_pkg::opnd_class_t b_i,
  input  fpu_pkg::fpu_op_e     op_i,
  output logic                 cmp_flag_o,
  output logic                 cmp_invalid_o,
  output logic                 a_mag_ge_b_o
);

  localparam int MAG_W = fpu_pkg::EXP_W + fpu_pkg::FRAC_W + 1;

  logic [MAG_W-1:0] mag_a;
  logic [MAG_W-1:0] mag_b;
  logic             mag_eq;
  logic             mag_gt;
  logic             unord;
  logic             both_zero;
  logic             eq;
  logic             lt;
  logic             any_qnan;
  logic             any_snan;

  // exponent above significand, so plain unsigned compare orders magnitudes
  assign mag_a  = {a_i.exp, a_i.sig};
  assign mag_b  = {b_i.exp, b_i.sig};
  assign mag_eq = (mag_a == mag_b);
  assign mag_gt = (mag_a > mag_b);

  assign a_mag_ge_b_o = mag_gt | mag_eq;  // swap control for the adder

  assign any_snan  = a_i.is_snan | b_i.is_snan;
  assign any_qnan  = a_i.is_qnan | b_i.is_qnan;
  assign unord     = any_snan | any_qnan;
  assign both_zero = a_i.is_zero & b_i.is_zero;  // +0 == -0

  assign eq = ~unord & (both_zero | ((a_i.sign == b_i.sign) & mag_eq));

  // neg < pos, else by magnitude, reversed when both negative
  assign lt = ~unord & ~both_zero &
              ((a_i.sign & ~b_i.sign) |
               (~a_i.sign & ~b_i.sign & ~(mag_gt | mag_eq)) |
               (a_i.sign & b_i.sign & mag_gt));

  always_comb begin
    case (op_i)
      fpu_pkg::OP_CMP_EQ: cmp_flag_o = eq;
      fpu_pkg::OP_CMP_LT: cmp_flag_o = lt;
      fpu_pkg::OP_CMP_LE: cmp_flag_o = lt | eq;
      fpu_pkg::OP_CMP_UN: cmp_flag_o = unord;
      default:            cmp_flag_o = 1'b0;  // add/sub, unused
    endcase
  end

  // ordered relations signal on quiet nan too
  assign cmp_invalid_o = any_snan |
                         (any_qnan & ((op_i == fpu_pkg::OP_CMP_LT) |
                                      (op_i == fpu_pkg::OP_CMP_LE)));

endmodule

/* fpu_addsub.sv */
`timescale 1ns/1ps

module fpu_addsub #(
  parameter int PIPE_ADD_STAGE = 1   // 1: register after align, 0: align with add
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,
  input  logic                 s1_valid_i,
  input  fpu_pkg::opnd_class_t a_i,
  input  fpu_pkg::opnd_class_t b_i,
  input  fpu_pkg::fpu_op_e     op_i,
  input  fpu_pkg::rmode_e      rmode_i,
  input  logic                 a_mag_ge_b_i,
  input  logic                 cmp_flag_i,
  input  logic                 cmp_invalid_i,
  fpu_stage_if.adder           stage
);

  localparam int EW    = fpu_pkg::EXP_W;
  localparam int ALN_W = fpu_pkg::SUM_W - 1;          // sum without carry
  localparam logic [EW-1:0] SH_MAX = EW'(ALN_W);      // beyond this all is sticky

  typedef struct packed {
    logic             sign;
    logic [EW-1:0]    exp;
    logic [ALN_W-1:0] sig_l;   // larger operand, g/r/s zero
    logic [ALN_W-1:0] sig_s;   // smaller operand, shifted with sticky
    logic             eff_sub;
    logic             nan;
    logic             snan;
    logic             inf_l;
    logic             inf_s;
  } align_t;

  //////////////////////////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////////////////////////
  function automatic align_t align_f(input fpu_pkg::opnd_class_t a,
                                     input fpu_pkg::opnd_class_t b,
                                     input logic sub,
                                     input logic ge);
    fpu_pkg::opnd_class_t l;
    fpu_pkg::opnd_class_t s;
    logic [EW-1:0]        diff;
    logic [EW-1:0]        sh;
    logic [2*ALN_W-1:0]   ext;
    align_t               r;
    b.sign = b.sign ^ sub;               // a - b == a + (-b)
    l      = ge ? a : b;
    s      = ge ? b : a;
    diff   = l.exp - s.exp;
    sh     = (diff > SH_MAX) ? SH_MAX : diff;
    // lower half catches everything shifted out
    ext    = {s.sig, 3'b000, {ALN_W{1'b0}}} >> sh;
    r.sign    = l.sign;
    r.exp     = l.exp;
    r.sig_l   = {l.sig, 3'b000};
    r.sig_s   = {ext[2*ALN_W-1:ALN_W+1], ext[ALN_W] | (|ext[ALN_W-1:0])};
    r.eff_sub = a.sign ^ b.sign;
    r.nan     = a.is_snan | a.is_qnan | b.is_snan | b.is_qnan;
    r.snan    = a.is_snan | b.is_snan;
    r.inf_l   = l.is_inf;
    r.inf_s   = s.is_inf;
    return r;
  endfunction

  fpu_pkg::fpu_op_e op_q;
  fpu_pkg::rmode_e  rm_q;
  logic             cmpf_q;
  logic             cmpi_q;
  align_t           al;
  logic [fpu_pkg::SUM_W-1:0] sum;
  logic             inf_inf;

  // stage 1, side payload
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_q   <= fpu_pkg::OP_ADD;
      rm_q   <= fpu_pkg::RM_NEAREST;
      cmpf_q <= 1'b0;
      cmpi_q <= 1'b0;
    end else if (adv_i) begin
      op_q   <= op_i;
      rm_q   <= rmode_i;
      cmpf_q <= cmp_flag_i;
      cmpi_q <= cmp_invalid_i;
    end
  end

  // stage 1, operands: aligned before or after the register
  if (PIPE_ADD_STAGE != 0) begin : g_align_reg
    align_t al_q;
    always_ff @(posedge clk) begin
      if (adv_i) al_q <= align_f(a_i, b_i, op_i == fpu_pkg::OP_SUB, a_mag_ge_b_i);
    end
    assign al = al_q;
  end else begin : g_align_comb
    fpu_pkg::opnd_class_t a_q;
    fpu_pkg::opnd_class_t b_q;
    logic                 ge_q;
    always_ff @(posedge clk) begin
      if (adv_i) begin
        a_q  <= a_i;
        b_q  <= b_i;
        ge_q <= a_mag_ge_b_i;
      end
    end
    assign al = align_f(a_q, b_q, op_q == fpu_pkg::OP_SUB, ge_q);
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, add and specials
  //////////////////////////////////////////////////////////////////////
  // larger minus smaller never goes negative
  assign sum = al.eff_sub ? ({1'b0, al.sig_l} - {1'b0, al.sig_s})
                          : ({1'b0, al.sig_l} + {1'b0, al.sig_s});
  assign inf_inf = al.inf_l & al.inf_s & al.eff_sub;  // inf - inf

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage.is_nan      <= 1'b0;
      stage.is_inf      <= 1'b0;
      stage.invalid     <= 1'b0;
      stage.eff_sub     <= 1'b0;
      stage.op          <= fpu_pkg::OP_ADD;
      stage.rmode       <= fpu_pkg::RM_NEAREST;
      stage.cmp_flag    <= 1'b0;
      stage.cmp_invalid <= 1'b0;
    end else if (adv_i && s1_valid_i) begin
      stage.is_nan      <= al.nan | inf_inf;
      stage.is_inf      <= al.inf_l;         // nan wins in the rounder
      stage.invalid     <= al.snan | inf_inf;
      stage.eff_sub     <= al.eff_sub;
      stage.op          <= op_q;
      stage.rmode       <= rm_q;
      stage.cmp_flag    <= cmpf_q;
      stage.cmp_invalid <= cmpi_q;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i && s1_valid_i) begin
      stage.sign <= al.sign;
      stage.exp  <= al.exp;
      stage.sig  <= sum;
    end
  end

endmodule

/* fpu_round.sv */
`timescale 1ns/1ps

module fpu_round (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        adv_i,
  input  logic                        s2_valid_i,
  input  logic                        out_full_i,
  fpu_stage_if.rounder                stage,
  output logic [fpu_pkg::WORD_W-1:0]  result_o,
  output logic                        result_valid_o,
  output logic                        cmp_flag_o,
  output logic                        cmp_valid_o,
  output fpu_pkg::fpcsr_t             fpcsr_o
);

  localparam int EW      = fpu_pkg::EXP_W;
  localparam int FW      = fpu_pkg::FRAC_W;
  localparam int EXP_MAX = 2 * fpu_pkg::EXP_BIAS + 1;   // all ones for inf and nan

  function automatic logic [4:0] lzc27(input logic [26:0] v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (v[i]) n = 5'(26 - i);   // highest set bit wins
    end
    return n;
  endfunction

  logic [4:0]              lz;
  logic [26:0]             norm;
  logic signed [9:0]       e_norm;
  logic signed [9:0]       e_rnd;
  logic [23:0]             mant;
  logic                    guard;
  logic                    rs;
  logic                    inexact;
  logic                    inc;
  logic                    ovf_to_inf;
  logic [24:0]             mr;
  logic [FW-1:0]           frac;
  logic                    sum_zero;
  logic                    ovf;
  logic                    unf;
  logic                    is_cmp;
  logic                    is_cmp_q;
  logic [fpu_pkg::WORD_W-1:0] word_d;
  fpu_pkg::fpcsr_t         flags_d;

  //////////////////////////////////////////////////////////////////////
  // normalize
  //////////////////////////////////////////////////////////////////////
  assign lz       = lzc27(stage.sig[26:0]);
  assign sum_zero = (stage.sig == '0);

  always_comb begin
    if (stage.sig[fpu_pkg::SUM_W-1]) begin
      // carry out needs one right shift that keeps the sticky
      norm   = {stage.sig[27:2], stage.sig[1] | stage.sig[0]};
      e_norm = $signed({2'b00, stage.exp}) + 10'sd1;
    end else begin
      norm   = stage.sig[26:0] << lz;   // cancellation after true sub
      e_norm = $signed({2'b00, stage.exp}) - $signed({5'b00000, lz});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // round by mode
  //////////////////////////////////////////////////////////////////////
  assign mant    = norm[26:3];
  assign guard   = norm[2];
  assign rs      = norm[1] | norm[0];
  assign inexact = guard | rs;

  always_comb begin
    case (stage.rmode)
      fpu_pkg::RM_NEAREST: begin
        inc        = guard & (rs | mant[0]);   // tie goes to even
        ovf_to_inf = 1'b1;
      end
      fpu_pkg::RM_ZERO: begin
        inc        = 1'b0;
        ovf_to_inf = 1'b0;
      end
      fpu_pkg::RM_PLUS_INF: begin
        inc        = ~stage.sign & inexact;
        ovf_to_inf = ~stage.sign;
      end
      default: begin
        inc        = stage.sign & inexact;
        ovf_to_inf = stage.sign;
      end
    endcase
  end

  assign mr    = {1'b0, mant} + 25'(inc);
  assign frac  = mr[FW-1:0];                        // roll-over leaves the low bits zero
  assign e_rnd = e_norm + $signed({9'b0, mr[24]});
  assign ovf   = (e_rnd >= EXP_MAX);
  assign unf   = (e_rnd < 10'sd1);                 // too small to represent

  assign is_cmp = (stage.op != fpu_pkg::OP_ADD) && (stage.op != fpu_pkg::OP_SUB);

  // pack with special cases in priority order
  always_comb begin
    flags_d = '0;
    if (stage.is_nan) begin
      word_d          = fpu_pkg::CANONICAL_NAN;
      flags_d.invalid = stage.invalid;
    end else if (stage.is_inf) begin
      word_d = {stage.sign, {EW{1'b1}}, {FW{1'b0}}};
    end else if (sum_zero) begin
      // exact cancellation is -0 only when rounding down
      word_d       = {stage.eff_sub ? (stage.rmode == fpu_pkg::RM_MINUS_INF) : stage.sign,
                      {(EW+FW){1'b0}}};
      flags_d.zero = 1'b1;
    end else if (unf) begin
      word_d          = {stage.sign, {(EW+FW){1'b0}}};
      flags_d.zero    = 1'b1;
      flags_d.inexact = 1'b1;
    end else if (ovf) begin
      word_d = ovf_to_inf ? {stage.sign, {EW{1'b1}}, {FW{1'b0}}}
                          : {stage.sign, EW'(EXP_MAX - 1), {FW{1'b1}}};  // max finite
      flags_d.overflow = 1'b1;
      flags_d.inexact  = 1'b1;
    end else begin
      word_d          = {stage.sign, e_rnd[EW-1:0], frac};
      flags_d.inexact = inexact;
    end
    if (is_cmp) begin
      flags_d         = '0;
      flags_d.invalid = stage.cmp_invalid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register holds until taken
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      is_cmp_q <= 1'b0;
      fpcsr_o  <= '0;
    end else if (adv_i && s2_valid_i) begin
      is_cmp_q <= is_cmp;
      fpcsr_o  <= flags_d;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i && s2_valid_i) begin
      result_o   <= word_d;
      cmp_flag_o <= stage.cmp_flag;
    end
  end

  assign result_valid_o = out_full_i & ~is_cmp_q;
  assign cmp_valid_o    = out_full_i & is_cmp_q;

endmodule

/* fpu_top.sv */
`timescale 1ns/1ps

module fpu_top #(
  parameter int PIPE_ADD_STAGE = 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush_i,
  input  logic                        issue_i,
  input  logic [2:0]                  op_i,
  input  logic [1:0]                  rmode_i,
  input  logic [fpu_pkg::WORD_W-1:0]  opa_i,
  input  logic [fpu_pkg::WORD_W-1:0]  opb_i,
  input  logic                        take_i,
  output logic                        ready_o,
  output logic [fpu_pkg::WORD_W-1:0]  result_o,
  output logic                        result_valid_o,
  output logic                        cmp_flag_o,
  output logic                        cmp_valid_o,
  output logic [3:0]                  fpcsr_o
);

  fpu_pkg::fpu_op_e     op;
  fpu_pkg::rmode_e      rmode;
  fpu_pkg::opnd_class_t a_cls;
  fpu_pkg::opnd_class_t b_cls;
  logic                 adv;
  logic                 out_full;
  logic                 s1_valid;
  logic                 s2_valid;
  logic                 cmp_flag;
  logic                 cmp_invalid;
  logic                 a_mag_ge_b;

  assign op    = fpu_pkg::fpu_op_e'(op_i);
  assign rmode = fpu_pkg::rmode_e'(rmode_i);

  fpu_stage_if stage_if ();   // adder -> rounder

  fpu_issue_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .issue_i    (issue_i),
    .take_i     (take_i),
    .ready_o    (ready_o),
    .out_full_o (out_full),
    .adv_o      (adv),
    .s1_valid_o (s1_valid),
    .s2_valid_o (s2_valid)
  );

  fpu_operand_class u_class_a (.word_i(opa_i), .class_o(a_cls));
  fpu_operand_class u_class_b (.word_i(opb_i), .class_o(b_cls));

  fpu_fcmp u_fcmp (
    .a_i           (a_cls),
    .b_i           (b_cls),
    .op_i          (op),
    .cmp_flag_o    (cmp_flag),
    .cmp_invalid_o (cmp_invalid),
    .a_mag_ge_b_o  (a_mag_ge_b)
  );

  fpu_addsub #(
    .PIPE_ADD_STAGE (PIPE_ADD_STAGE)
  ) u_addsub (
    .clk           (clk),
    .rst           (rst),
    .adv_i         (adv),
    .s1_valid_i    (s1_valid),
    .a_i           (a_cls),
    .b_i           (b_cls),
    .op_i          (op),
    .rmode_i       (rmode),
    .a_mag_ge_b_i  (a_mag_ge_b),
    .cmp_flag_i    (cmp_flag),
    .cmp_invalid_i (cmp_invalid),
    .stage         (stage_if.adder)
  );

  fpu_round u_round (
    .clk            (clk),
    .rst            (rst),
    .adv_i          (adv),
    .s2_valid_i     (s2_valid),
    .out_full_i     (out_full),
    .stage          (stage_if.rounder),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .cmp_flag_o     (cmp_flag_o),
    .cmp_valid_o    (cmp_valid_o),
    .fpcsr_o        (fpcsr_o)
  );

endmodule

/* fpu_tb_sva.sv */
`timescale 1ns/1ps

module fpu_sva (
  input logic        clk,
  input logic        rst,
  input logic        flush_i,
  input logic        take_i,
  input logic        ready_o,
  input logic [31:0] result_o,
  input logic        result_valid_o,
  input logic        cmp_flag_o,
  input logic        cmp_valid_o,
  input logic [3:0]  fpcsr_o
);

  logic held;   // output register occupied

  assign held = result_valid_o | cmp_valid_o;

  //////////////////////////////////////////////////////////////////////
  // output protocol
  //////////////////////////////////////////////////////////////////////
  reset_idle: assert property (@(posedge clk) $past(rst) |-> !held)
    else $error("output valid right after reset");

  one_valid: assert property (@(posedge clk) disable iff (rst)
    !(result_valid_o && cmp_valid_o))
    else $error("result_valid_o and cmp_valid_o high together");

  // frozen while the core does not take it, a flush may still drop it
  held_stable: assert property (@(posedge clk) disable iff (rst)
    (held && !take_i && !flush_i) |=> $stable(result_o) && $stable(cmp_flag_o) &&
                                      $stable(fpcsr_o) && $stable(result_valid_o) &&
                                      $stable(cmp_valid_o))
    else $error("held result changed while take_i was low");

  ready_rule: assert property (@(posedge clk) disable iff (rst)
    ready_o == (!held || take_i))
    else $error("ready_o does not follow output occupancy and take_i");

endmodule

bind fpu_top fpu_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .flush_i        (flush_i),
  .take_i         (take_i),
  .ready_o        (ready_o),
  .result_o       (result_o),
  .result_valid_o (result_valid_o),
  .cmp_flag_o     (cmp_flag_o),
  .cmp_valid_o    (cmp_valid_o),
  .fpcsr_o        (fpcsr_o)
);

/* fpu_tb.sv */
`timescale 1ns/1ps

module fpu_tb;

  // short names for the table rows
  localparam logic [2:0] ADD = fpu_pkg::OP_ADD;
  localparam logic [2:0] SUB = fpu_pkg::OP_SUB;
  localparam logic [2:0] EQ  = fpu_pkg::OP_CMP_EQ;
  localparam logic [2:0] LT  = fpu_pkg::OP_CMP_LT;
  localparam logic [2:0] LE  = fpu_pkg::OP_CMP_LE;
  localparam logic [2:0] UN  = fpu_pkg::OP_CMP_UN;
  localparam logic [1:0] RN  = fpu_pkg::RM_NEAREST;
  localparam logic [1:0] RZ  = fpu_pkg::RM_ZERO;
  localparam logic [1:0] RP  = fpu_pkg::RM_PLUS_INF;
  localparam logic [1:0] RM  = fpu_pkg::RM_MINUS_INF;

  typedef struct packed {
    logic [2:0]  op;
    logic [1:0]  rm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;   // word, or the flag in bit 0 for compares
    logic [3:0]  csr;   // invalid overflow inexact zero
  } vec_t;

  logic        clk;
  logic        rst;
  logic        flush_i;
  logic        issue_i;
  logic [2:0]  op_i;
  logic [1:0]  rmode_i;
  logic [31:0] opa_i;
  logic [31:0] opb_i;
  logic        take_i;
  logic        ready_o;
  logic [31:0] result_o;
  logic        result_valid_o;
  logic        cmp_flag_o;
  logic        cmp_valid_o;
  logic [3:0]  fpcsr_o;

  vec_t vecs[$];
  int   exp_idx[$];   // accepted ops in issue order
  int   exp_cyc[$];   // cycle of acceptance
  int   cur_vec;
  int   cycle;
  int   mismatches;
  int   failures;
  bit   random_take;
  bit   check_lat;    // exact 3 cycle latency only with take held high
  bit   stall_seen;

  fpu_top #(.PIPE_ADD_STAGE(1)) UUT (
    .clk (clk), .rst (rst), .flush_i (flush_i), .issue_i (issue_i),
    .op_i (op_i), .rmode_i (rmode_i), .opa_i (opa_i), .opb_i (opb_i),
    .take_i (take_i), .ready_o (ready_o), .result_o (result_o),
    .result_valid_o (result_valid_o), .cmp_flag_o (cmp_flag_o),
    .cmp_valid_o (cmp_valid_o), .fpcsr_o (fpcsr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // take_i, random only in the back-pressure phase
  initial begin : take_drive
    logic [31:0] r;
    r = $urandom(32'h64a3);
    take_i = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      r = $urandom;
      take_i = random_take ? r[0] : 1'b1;
    end
  end

  task automatic add_vec(input logic [2:0] op, input logic [1:0] rm, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] res, input logic [3:0] csr);
    vecs.push_back(vec_t'({op, rm, a, b, res, csr}));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////
  task automatic fill_table();
    add_vec(ADD, RN, 32'h3FC00000, 32'h40100000, 32'h40700000, 4'b0000); // 1.5 + 2.25
    add_vec(SUB, RN, 32'h40400000, 32'h40400000, 32'h00000000, 4'b0001); // 3 - 3
    add_vec(SUB, RM, 32'h40400000, 32'h40400000, 32'h80000000, 4'b0001); // -0 rounding down
    add_vec(SUB, RN, 32'h3F800000, 32'h40000000, 32'hBF800000, 4'b0000); // 1 - 2
    add_vec(ADD, RN, 32'h3F800000, 32'h33800000, 32'h3F800000, 4'b0010); // tie, stays even
    add_vec(ADD, RZ, 32'h3F800000, 32'h33800000, 32'h3F800000, 4'b0010);
    add_vec(ADD, RP, 32'h3F800000, 32'h33800000, 32'h3F800001, 4'b0010);
    add_vec(ADD, RM, 32'h3F800000, 32'h33800000, 32'h3F800000, 4'b0010);
    add_vec(ADD, RN, 32'h3F800000, 32'h34400000, 32'h3F800002, 4'b0010); // tie, odd goes up
    add_vec(ADD, RZ, 32'h3F800000, 32'h34400000, 32'h3F800001, 4'b0010);
    add_vec(ADD, RP, 32'h3F800000, 32'h34400000, 32'h3F800002, 4'b0010);
    add_vec(ADD, RM, 32'h3F800000, 32'h34400000, 32'h3F800001, 4'b0010);
    add_vec(ADD, RP, 32'hBF800000, 32'hB3800000, 32'hBF800000, 4'b0010); // negative side
    add_vec(ADD, RM, 32'hBF800000, 32'hB3800000, 32'hBF800001, 4'b0010);
    add_vec(ADD, RN, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 4'b0110); // overflow
    add_vec(ADD, RZ, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F7FFFFF, 4'b0110);
    add_vec(ADD, RM, 32'hFF7FFFFF, 32'hFF7FFFFF, 32'hFF800000, 4'b0110);
    add_vec(SUB, RN, 32'h7F800000, 32'h7F800000, 32'h7FC00000, 4'b1000); // inf - inf
    add_vec(ADD, RN, 32'h7F800001, 32'h3F800000, 32'h7FC00000, 4'b1000); // snan
    add_vec(ADD, RN, 32'h3F800000, 32'h7FC12345, 32'h7FC00000, 4'b0000); // qnan
    add_vec(ADD, RN, 32'h7F800000, 32'h40000000, 32'h7F800000, 4'b0000);
    add_vec(ADD, RN, 32'hFF800000, 32'h3F800000, 32'hFF800000, 4'b0000);
    add_vec(EQ,  RN, 32'h3F800000, 32'h3F800000, 32'h1, 4'b0000);
    add_vec(EQ,  RN, 32'h3F800000, 32'h40000000, 32'h0, 4'b0000);
    add_vec(LT,  RN, 32'h3F800000, 32'h40000000, 32'h1, 4'b0000);
    add_vec(LT,  RN, 32'h40000000, 32'h3F800000, 32'h0, 4'b0000);
    add_vec(LE,  RN, 32'hC0000000, 32'hBF800000, 32'h1, 4'b0000); // -2 <= -1
    add_vec(LT,  RN, 32'hBF800000, 32'hC0000000, 32'h0, 4'b0000);
    add_vec(LE,  RN, 32'h40000000, 32'h40000000, 32'h1, 4'b0000);
    add_vec(EQ,  RN, 32'h00000000, 32'h80000000, 32'h1, 4'b0000); // +0 == -0
    add_vec(LT,  RN, 32'h80000000, 32'h00000000, 32'h0, 4'b0000);
    add_vec(EQ,  RN, 32'h7FC00000, 32'h3F800000, 32'h0, 4'b0000);
    add_vec(LT,  RN, 32'h7FC00000, 32'h3F800000, 32'h0, 4'b1000); // qnan signals on lt
    add_vec(LE,  RN, 32'h3F800000, 32'h7FC00000, 32'h0, 4'b1000);
    add_vec(UN,  RN, 32'h7FC00000, 32'h3F800000, 32'h1, 4'b0000);
    add_vec(UN,  RN, 32'h3F800000, 32'h40000000, 32'h0, 4'b0000);
    add_vec(EQ,  RN, 32'h7F800001, 32'h3F800000, 32'h0, 4'b1000);
  endtask

  task automatic mismatch(input string msg);
    mismatches++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic check_result(input int idx, input int cyc);
    vec_t v;
    logic is_cmp;
    v = vecs[idx];
    is_cmp = (v.op != ADD) && (v.op != SUB);   // compares report on cmp_valid_o
    if (is_cmp != cmp_valid_o)
      mismatch($sformatf("vector %0d on the wrong valid", idx));
    if (is_cmp && cmp_flag_o !== v.res[0])
      mismatch($sformatf("vector %0d flag %b expected %b", idx, cmp_flag_o, v.res[0]));
    if (!is_cmp && result_o !== v.res)
      mismatch($sformatf("vector %0d result %h expected %h", idx, result_o, v.res));
    if (fpcsr_o !== v.csr)
      mismatch($sformatf("vector %0d fpcsr %b expected %b", idx, fpcsr_o, v.csr));
    if (check_lat && (cycle - cyc) != 3)
      mismatch($sformatf("vector %0d latency %0d expected 3", idx, cycle - cyc));
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor, samples mid-cycle
  //////////////////////////////////////////////////////////////////////
  task automatic observe();
    logic held;
    held = result_valid_o | cmp_valid_o;
    if (held && !take_i) begin
      stall_seen = 1'b1;
      if (ready_o) begin
        failures++;
        $display("ready_o stayed high at %0t while a result was held", $time);
      end
    end
    if (held && take_i) begin
      if (exp_idx.size() == 0) begin
        failures++;
        $display("an output appeared at %0t with no operation in flight", $time);
      end else begin
        check_result(exp_idx.pop_front(), exp_cyc.pop_front());
      end
    end
    if (flush_i) begin   // everything in flight is gone
      exp_idx.delete();
      exp_cyc.delete();
    end else if (issue_i && ready_o) begin
      exp_idx.push_back(cur_vec);
      exp_cyc.push_back(cycle);
    end
  endtask

  initial begin : monitor
    cycle = 0;
    forever begin
      @(negedge clk);
      cycle = cycle + 1;
      if (!rst) observe();
    end
  end

  task automatic drive_inputs(input int idx);
    cur_vec = idx;
    op_i    = vecs[idx].op;
    rmode_i = vecs[idx].rm;
    opa_i   = vecs[idx].a;
    opb_i   = vecs[idx].b;
    issue_i = 1'b1;
  endtask

  // called at posedge + 1, returns there once the op is taken
  task automatic send(input int idx);
    int   waited;
    logic taken;
    drive_inputs(idx);
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < 50) begin
      @(negedge clk);
      taken = ready_o;
      @(posedge clk);
      #1;
      waited++;
    end
    issue_i = 1'b0;
    if (!taken) begin
      failures++;
      $display("timeout, vector %0d was never accepted", idx);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_idx.size() != 0 && waited < 50) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_idx.size() != 0) begin
      failures++;
      $display("timeout, %0d results never came out", exp_idx.size());
    end
  endtask

  initial begin : main
    rst         = 1'b1;
    flush_i     = 1'b0;
    issue_i     = 1'b0;
    op_i        = 3'd0;
    rmode_i     = 2'd0;
    opa_i       = 32'h0;
    opb_i       = 32'h0;
    cur_vec     = 0;
    mismatches  = 0;
    failures    = 0;
    random_take = 1'b0;
    check_lat   = 1'b1;
    stall_seen  = 1'b0;
    fill_table();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (result_valid_o || cmp_valid_o || !ready_o) begin
      failures++;
      $display("outputs not idle after reset");
    end
    @(posedge clk);
    #1;

    // back to back with take held high
    for (int i = 0; i < vecs.size(); i++) send(i);
    drain();

    // flush kills two in flight plus the one issued with it
    send(0);
    send(1);
    drive_inputs(2);
    flush_i = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    issue_i = 1'b0;
    repeat (6) @(posedge clk);   // monitor catches any stray output
    #1;
    send(3);
    send(4);
    drain();

    // random back-pressure, order and values only
    check_lat   = 1'b0;
    random_take = 1'b1;
    for (int i = 0; i < vecs.size(); i++) send(i);
    drain();
    if (!stall_seen) begin
      failures++;
      $display("random take_i never held a result");
    end

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
fpu_pkg.sv
fpu_stage_if.sv
fpu_operand_class.sv
fpu_issue_ctrl.sv
fpu_fcmp.sv
fpu_addsub.sv
fpu_round.sv
fpu_top.sv
fpu_tb_sva.sv
fpu_tb.sv

/* Makefile */
TOP = fpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
